// ==== rv_core_pkg.sv ====
package rv_core_pkg;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW = $clog2(DMEM_WORDS); // word index width
	localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_e;

	// one entry per implemented instruction
	typedef enum logic [4:0] {
		alu_none,
		alu_lui,
		alu_auipc,
		alu_jal,
		alu_jalr,
		alu_beq,
		alu_bne,
		alu_bge,
		alu_lw,
		alu_lbu,
		alu_sb,
		alu_sh,
		alu_sw,
		alu_addi,
		alu_sltiu,
		alu_xori,
		alu_andi,
		alu_slli,
		alu_srai,
		alu_add,
		alu_sll,
		alu_sltu,
		alu_and,
		alu_ebreak
	} alu_op_e;

	typedef struct packed {
		alu_op_e     alu_op;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
		logic        reg_we;
		logic        is_load;
		logic        is_store;
		logic        is_halt;
	} decoded_t;

	typedef struct packed {
		logic [31:0] val;
		logic        jump_taken;
		logic [31:0] jump_target;
	} exu_result_t;

	typedef struct packed {
		logic        valid;
		logic        wen;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wmask;
		logic        load_byte; // zero-extended low byte for lbu
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] wdata;
		logic        we;
	} commit_t;

endpackage

// ==== ifu.sv ====
`timescale 1ns/1ps

module ifu (
	input  logic                     clk,
	input  logic                     rst_n,
	input  rv_core_pkg::exu_result_t exu_res,
	input  logic                     halt_req,
	output logic [31:0]              pc,
	output logic                     halted
);

	logic [31:0] pc_plus4;
	logic [31:0] next_pc;

	assign pc_plus4 = pc + 32'd4;
	assign next_pc = exu_res.jump_taken ? exu_res.jump_target : pc_plus4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= rv_core_pkg::RESET_PC;
			halted <= 1'b0;
		end else begin
			if (!halted && !halt_req) begin
				pc <= next_pc;
			end
			if (halt_req) begin
				halted <= 1'b1; // sticky until reset
			end
		end
	end

endmodule

// ==== idu.sv ====
`timescale 1ns/1ps

module idu (
	input  logic [31:0]           inst,
	output rv_core_pkg::decoded_t dec
);

	rv_core_pkg::opcode_e opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opc = rv_core_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.alu_op = rv_core_pkg::alu_none;
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.rd = inst[11:7];
		case (opc)
			rv_core_pkg::opc_lui: begin
				dec.alu_op = rv_core_pkg::alu_lui;
				dec.imm = imm_u;
			end
			rv_core_pkg::opc_auipc: begin
				dec.alu_op = rv_core_pkg::alu_auipc;
				dec.imm = imm_u;
			end
			rv_core_pkg::opc_jal: begin
				dec.alu_op = rv_core_pkg::alu_jal;
				dec.imm = imm_j;
			end
			rv_core_pkg::opc_jalr: begin
				dec.imm = imm_i;
				if (funct3 == 3'b000) dec.alu_op = rv_core_pkg::alu_jalr;
			end
			rv_core_pkg::opc_branch: begin
				dec.imm = imm_b;
				case (funct3)
					3'b000: dec.alu_op = rv_core_pkg::alu_beq;
					3'b001: dec.alu_op = rv_core_pkg::alu_bne;
					3'b101: dec.alu_op = rv_core_pkg::alu_bge;
					default: dec.alu_op = rv_core_pkg::alu_none;
				endcase
			end
			rv_core_pkg::opc_load: begin
				dec.imm = imm_i;
				case (funct3)
					3'b010: dec.alu_op = rv_core_pkg::alu_lw;
					3'b100: dec.alu_op = rv_core_pkg::alu_lbu;
					default: dec.alu_op = rv_core_pkg::alu_none;
				endcase
			end
			rv_core_pkg::opc_store: begin
				dec.imm = imm_s;
				case (funct3)
					3'b000: dec.alu_op = rv_core_pkg::alu_sb;
					3'b001: dec.alu_op = rv_core_pkg::alu_sh;
					3'b010: dec.alu_op = rv_core_pkg::alu_sw;
					default: dec.alu_op = rv_core_pkg::alu_none;
				endcase
			end
			rv_core_pkg::opc_op_imm: begin
				dec.imm = imm_i;
				case (funct3)
					3'b000: dec.alu_op = rv_core_pkg::alu_addi;
					3'b011: dec.alu_op = rv_core_pkg::alu_sltiu;
					3'b100: dec.alu_op = rv_core_pkg::alu_xori;
					3'b111: dec.alu_op = rv_core_pkg::alu_andi;
					3'b001: if (funct7 == 7'b0000000) dec.alu_op = rv_core_pkg::alu_slli;
					3'b101: if (funct7 == 7'b0100000) dec.alu_op = rv_core_pkg::alu_srai;
					default: dec.alu_op = rv_core_pkg::alu_none;
				endcase
			end
			rv_core_pkg::opc_op: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: dec.alu_op = rv_core_pkg::alu_add;
						3'b001: dec.alu_op = rv_core_pkg::alu_sll;
						3'b011: dec.alu_op = rv_core_pkg::alu_sltu;
						3'b111: dec.alu_op = rv_core_pkg::alu_and;
						default: dec.alu_op = rv_core_pkg::alu_none;
					endcase
				end
			end
			rv_core_pkg::opc_system: begin
				if (inst == rv_core_pkg::EBREAK_INST) dec.alu_op = rv_core_pkg::alu_ebreak;
			end
			default: dec.alu_op = rv_core_pkg::alu_none;
		endcase

		case (dec.alu_op)
			rv_core_pkg::alu_none, rv_core_pkg::alu_ebreak,
			rv_core_pkg::alu_beq, rv_core_pkg::alu_bne, rv_core_pkg::alu_bge,
			rv_core_pkg::alu_sb, rv_core_pkg::alu_sh, rv_core_pkg::alu_sw: dec.reg_we = 1'b0;
			default: dec.reg_we = 1'b1;
		endcase
		dec.is_load = (dec.alu_op == rv_core_pkg::alu_lw) || (dec.alu_op == rv_core_pkg::alu_lbu);
		dec.is_store = (dec.alu_op == rv_core_pkg::alu_sb) || (dec.alu_op == rv_core_pkg::alu_sh) ||
			(dec.alu_op == rv_core_pkg::alu_sw);
		dec.is_halt = (dec.alu_op == rv_core_pkg::alu_ebreak);
		if (!dec.reg_we) dec.rd = 5'd0; // no destination
	end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [1:31]; // x0 not stored

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

// ==== exu.sv ====
`timescale 1ns/1ps

module exu (
	input  rv_core_pkg::decoded_t    dec,
	input  logic [31:0]              src1,
	input  logic [31:0]              src2,
	input  logic [31:0]              pc,
	input  logic [31:0]              mem_rdata,
	output rv_core_pkg::exu_result_t result,
	output rv_core_pkg::mem_req_t    mem_req
);

	logic [31:0] src1_imm;
	logic [31:0] pc_imm;
	logic [31:0] pc_plus4;
	logic        eq;
	logic        ge_signed;

	assign src1_imm = src1 + dec.imm;
	assign pc_imm = pc + dec.imm;
	assign pc_plus4 = pc + 32'd4;
	assign eq = (src1 == src2);
	assign ge_signed = ($signed(src1) >= $signed(src2));

	always_comb begin
		result = '0;
		case (dec.alu_op)
			rv_core_pkg::alu_lui: result.val = dec.imm;
			rv_core_pkg::alu_auipc: result.val = pc_imm;
			rv_core_pkg::alu_jal: begin
				result.val = pc_plus4; // link
				result.jump_taken = 1'b1;
				result.jump_target = pc_imm;
			end
			rv_core_pkg::alu_jalr: begin
				result.val = pc_plus4;
				result.jump_taken = 1'b1;
				result.jump_target = {src1_imm[31:1], 1'b0};
			end
			rv_core_pkg::alu_beq: begin
				result.jump_taken = eq;
				result.jump_target = pc_imm;
			end
			rv_core_pkg::alu_bne: begin
				result.jump_taken = !eq;
				result.jump_target = pc_imm;
			end
			rv_core_pkg::alu_bge: begin
				result.jump_taken = ge_signed;
				result.jump_target = pc_imm;
			end
			rv_core_pkg::alu_lw, rv_core_pkg::alu_lbu: result.val = mem_rdata; // shaped in lsu
			rv_core_pkg::alu_addi: result.val = src1_imm;
			rv_core_pkg::alu_sltiu: result.val = {31'b0, src1 < dec.imm};
			rv_core_pkg::alu_xori: result.val = src1 ^ dec.imm;
			rv_core_pkg::alu_andi: result.val = src1 & dec.imm;
			rv_core_pkg::alu_slli: result.val = src1 << dec.imm[4:0];
			rv_core_pkg::alu_srai: result.val = $signed(src1) >>> dec.imm[4:0];
			rv_core_pkg::alu_add: result.val = src1 + src2;
			rv_core_pkg::alu_sll: result.val = src1 << src2[4:0];
			rv_core_pkg::alu_sltu: result.val = {31'b0, src1 < src2};
			rv_core_pkg::alu_and: result.val = src1 & src2;
			default: result = '0;
		endcase
	end

	always_comb begin
		mem_req = '0;
		mem_req.valid = dec.is_load || dec.is_store;
		mem_req.wen = dec.is_store;
		mem_req.addr = src1_imm;
		mem_req.wdata = src2;
		mem_req.load_byte = (dec.alu_op == rv_core_pkg::alu_lbu);
		case (dec.alu_op)
			rv_core_pkg::alu_sb: mem_req.wmask = 4'h1;
			rv_core_pkg::alu_sh: mem_req.wmask = 4'h3;
			rv_core_pkg::alu_sw: mem_req.wmask = 4'hf;
			default: mem_req.wmask = 4'h0;
		endcase
	end

endmodule

// ==== lsu.sv ====
`timescale 1ns/1ps

module lsu (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::mem_req_t req,
	output logic [31:0]           rdata
);

	logic [31:0] mem [0:rv_core_pkg::DMEM_WORDS-1];
	logic [rv_core_pkg::DMEM_AW-1:0] widx;
	logic [31:0] word;

	assign widx = req.addr[rv_core_pkg::DMEM_AW+1:2]; // drop byte offset
	assign word = mem[widx];

	always_comb begin
		if (!req.valid) begin
			rdata = 32'b0;
		end else if (req.load_byte) begin
			rdata = {24'b0, word[7:0]};
		end else begin
			rdata = word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rv_core_pkg::DMEM_WORDS; i++) begin
				mem[i] <= 32'b0;
			end
		end else if (req.valid && req.wen) begin
			for (int b = 0; b < 4; b++) begin
				if (req.wmask[b]) begin
					mem[widx][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          inst,
	output logic [31:0]          pc,
	output rv_core_pkg::commit_t commit,
	output logic                 halted
);

	rv_core_pkg::decoded_t    dec;
	rv_core_pkg::exu_result_t exu_res;
	rv_core_pkg::mem_req_t    mem_req;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	logic [31:0] mem_rdata;

	ifu ifu0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.exu_res  (exu_res),
		.halt_req (dec.is_halt),
		.pc       (pc),
		.halted   (halted)
	);

	idu idu0 (
		.inst (inst),
		.dec  (dec)
	);

	regfile regfile0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rd     (dec.rd),
		.we     (dec.reg_we),
		.wdata  (exu_res.val),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	exu exu0 (
		.dec       (dec),
		.src1      (rdata1),
		.src2      (rdata2),
		.pc        (pc),
		.mem_rdata (mem_rdata),
		.result    (exu_res),
		.mem_req   (mem_req)
	);

	lsu lsu0 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

	assign commit.valid = rst_n && !halted; // retires at next edge
	assign commit.pc = pc;
	assign commit.rd = dec.rd;
	assign commit.wdata = exu_res.val;
	assign commit.we = dec.reg_we;

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

	localparam int MAX_WAIT = 200; // cycles per wait loop
	localparam int IMEM_WORDS = 64;

	logic clk;
	logic rst_n;
	logic [31:0] inst;
	logic [31:0] pc;
	rv_core_pkg::commit_t commit;
	logic halted;

	logic [31:0] imem [0:IMEM_WORDS-1];
	logic [31:0] exp_pc [$];
	logic [4:0] exp_rd [$];
	logic exp_we [$];
	logic [31:0] exp_wdata [$];
	string test_name [$];
	int test_first [$]; // first expected entry of each test
	int n_pass;
	int n_fail;
	int entry;

	rv_core dut0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.inst   (inst),
		.pc     (pc),
		.commit (commit),
		.halted (halted)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (addr[31:8] == 24'd0) begin
			return imem[addr[7:2]];
		end
		return rv_core_pkg::EBREAK_INST; // outside the program
	endfunction

	// instruction memory model that follows pc once per cycle
	initial begin
		inst = rv_core_pkg::EBREAK_INST;
		forever begin
			@(posedge clk);
			#1 inst = fetch_word(pc);
		end
	end

	task automatic load_stimulus();
		int fd;
		int code;
		string tag;
		string rest;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd = $fopen("rv_core_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open rv_core_stimulus.txt");
			n_fail++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "P") begin
				code = $fscanf(fd, "%h %h", a, b);
				if (code != 2) begin
					$display("malformed program line in the stimulus file");
					n_fail++;
				end else if (a[31:6] == 26'd0) begin
					imem[a[5:0]] = b;
				end else begin
					$display("program word address %h is outside instruction memory", a);
					n_fail++;
				end
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
				if (code != 4) begin
					$display("malformed expected line in the stimulus file");
					n_fail++;
				end else begin
					exp_pc.push_back(a);
					exp_rd.push_back(b[4:0]);
					exp_we.push_back(c[0]);
					exp_wdata.push_back(d);
				end
			end else if (tag == "T") begin
				code = $fscanf(fd, "%s", rest);
				if (code != 1) begin
					$display("test line without a name in the stimulus file");
					n_fail++;
				end else begin
					test_name.push_back(rest);
					test_first.push_back(exp_pc.size());
				end
			end else begin
				code = $fgets(rest, fd); // comment line
			end
		end
		$fclose(fd);
	endtask

	task automatic wait_commit(output bit seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < MAX_WAIT) begin
			@(negedge clk);
			cycles++;
			seen = commit.valid;
		end
	endtask

	function automatic int check_entry(input int k);
		int errs;
		errs = 0;
		if (commit.pc !== exp_pc[k]) begin
			$display("MISMATCH commit.pc expected %h actual %h", exp_pc[k], commit.pc);
			errs++;
		end
		if (commit.rd !== exp_rd[k]) begin
			$display("MISMATCH commit.rd expected %h actual %h", exp_rd[k], commit.rd);
			errs++;
		end
		if (commit.we !== exp_we[k]) begin
			$display("MISMATCH commit.we expected %h actual %h", exp_we[k], commit.we);
			errs++;
		end
		if (commit.wdata !== exp_wdata[k]) begin
			$display("MISMATCH commit.wdata expected %h actual %h", exp_wdata[k], commit.wdata);
			errs++;
		end
		if (halted !== 1'b0) begin
			$display("MISMATCH halted expected %h actual %h", 1'b0, halted);
			errs++;
		end
		return errs;
	endfunction

	initial begin
		int errs;
		int last;
		int cycles;
		bit seen;
		rst_n = 1'b0;
		n_pass = 0;
		n_fail = 0;
		entry = 0;
		imem = '{default: rv_core_pkg::EBREAK_INST};
		load_stimulus();

		@(posedge clk);
		@(negedge clk);
		errs = 0;
		if (pc !== rv_core_pkg::RESET_PC) begin
			$display("MISMATCH pc expected %h actual %h", rv_core_pkg::RESET_PC, pc);
			errs++;
		end
		if (commit.valid !== 1'b0) begin
			$display("MISMATCH commit.valid expected %h actual %h", 1'b0, commit.valid);
			errs++;
		end
		if (halted !== 1'b0) begin
			$display("MISMATCH halted expected %h actual %h", 1'b0, halted);
			errs++;
		end
		if (errs == 0) begin
			n_pass++;
			$display("test reset_hold: ok");
		end else begin
			n_fail++;
			$display("test reset_hold: failed with %0d errors", errs);
		end
		@(posedge clk);
		#1 rst_n = 1'b1;

		for (int t = 0; t < test_name.size(); t++) begin
			last = (t + 1 < test_name.size()) ? test_first[t + 1] : exp_pc.size();
			errs = 0;
			while (entry < last) begin
				wait_commit(seen);
				if (!seen) begin
					$display("timeout, no commit within %0d cycles for pc %h",
						MAX_WAIT, exp_pc[entry]);
					errs++;
					break;
				end
				errs += check_entry(entry);
				entry++;
			end
			entry = last;
			if (errs == 0) begin
				n_pass++;
				$display("test %s: ok", test_name[t]);
			end else begin
				n_fail++;
				$display("test %s: failed with %0d errors", test_name[t], errs);
			end
		end

		// after ebreak the core must hold with no commits
		errs = 0;
		cycles = 0;
		while (!halted && cycles < MAX_WAIT) begin
			@(negedge clk);
			cycles++;
			if (commit.valid) begin
				$display("commit at pc %h with no expected entry left", commit.pc);
				errs++;
			end
		end
		if (!halted) begin
			$display("timeout, halted did not rise within %0d cycles", MAX_WAIT);
			errs++;
		end else begin
			repeat (10) begin
				@(negedge clk);
				if (commit.valid !== 1'b0) begin
					$display("commit at pc %h with no expected entry left", commit.pc);
					errs++;
				end
				if (halted !== 1'b1) begin
					$display("MISMATCH halted expected %h actual %h", 1'b1, halted);
					errs++;
				end
			end
		end
		if (errs == 0) begin
			n_pass++;
			$display("test halt_hold: ok");
		end else begin
			n_fail++;
			$display("test halt_hold: failed with %0d errors", errs);
		end

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== rv_core_stimulus.txt ====
# P word_addr inst | E pc rd we wdata | T test_name
# all values in hex, expected entries in commit order
T reset_seq
P 00 123450b7
P 01 00001117
E 00000000 01 1 12345000
E 00000004 02 1 00001004
T alu
P 02 ff800193
P 03 4021d213
P 04 00f1c013
P 05 7ff17313
P 06 00533393
P 07 00439413
P 08 007414b3
P 09 0081b533
P 0a 0021f5b3
P 0b 00940633
P 0c 008006b3
E 00000008 03 1 fffffff8
E 0000000c 04 1 fffffffe
E 00000010 00 1 fffffff7
E 00000014 06 1 00000004
E 00000018 07 1 00000001
E 0000001c 08 1 00000010
E 00000020 09 1 00000020
E 00000024 0a 1 00000000
E 00000028 0b 1 00001000
E 0000002c 0c 1 00000030
E 00000030 0d 1 00000010
T control
P 0d 0080076f
P 0f 058387e7
P 16 00738463
P 18 00838463
P 19 00839463
P 1b 00739463
P 1c 0033d463
P 1e 0071d463
E 00000034 0e 1 00000038
E 0000003c 0f 1 00000040
E 00000058 00 0 00000000
E 00000060 00 0 00000000
E 00000064 00 0 00000000
E 0000006c 00 0 00000000
E 00000070 00 0 00000000
E 00000078 00 0 00000000
T memory
P 1f 04302023
P 20 04101023
P 21 04400023
P 22 04002803
P 23 04004883
E 0000007c 00 0 00000000
E 00000080 00 0 00000000
E 00000084 00 0 00000000
E 00000088 10 1 ffff50fe
E 0000008c 11 1 000000fe
T halt
P 24 00100073
E 00000090 00 0 00000000

// ==== rv_core.f ====
rv_core_pkg.sv
ifu.sv
idu.sv
regfile.sv
exu.sv
lsu.sv
rv_core.sv
tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -j 0 --top-module tb_rv_core -f rv_core.f -o sim_rv_core \
	> "$build_log" 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see $build_log"
	exit 1
fi

./obj_dir/sim_rv_core > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see $sim_log"
	exit 1
fi

if grep -q -x -F '** PASS **' "$sim_log"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $sim_log"
	exit 1
fi
